// File: verilog/clear_sync_config.svh
// clear sequencer configuration
// build-time switches shared by the synchronizer halves and the initiator FSM

`ifndef CLEAR_SYNC_CONFIG_SVH
`define CLEAR_SYNC_CONFIG_SVH

// --------------------
// crossing depth
// --------------------

// number of flops in every request and acknowledge synchronizer chain
`define CLEAR_SYNC_SYNC_STAGES 2

// --------------------
// reset behavior
// --------------------

// when set, an asynchronous reset of one side starts a clear sequence on both sides
`define CLEAR_SYNC_CLEAR_ON_RESET 1'b1

`endif

// File: verilog/clear_seq_pkg.sv
// clear sequence types
// phases carried across the crossing and the states of the initiator FSM

package clear_seq_pkg;

  // phase of the clear sequence as seen by both domains
  // isolate blocks traffic, clear wipes the crossing state, post-clear releases clear
  typedef enum logic [1:0] {
    CLEAR_PHASE_IDLE       = 2'd0,
    CLEAR_PHASE_ISOLATE    = 2'd1,
    CLEAR_PHASE_CLEAR      = 2'd2,
    CLEAR_PHASE_POST_CLEAR = 2'd3
  } clear_phase_e;

  // states of the locally triggered sequence
  // the two wait states cover the isolate acknowledge and the phase acknowledge
  // arriving in either order
  typedef enum logic [2:0] {
    INIT_IDLE             = 3'd0,
    INIT_ISOLATE          = 3'd1,
    INIT_WAIT_PHASE_ACK   = 3'd2,
    INIT_WAIT_ISOLATE_ACK = 3'd3,
    INIT_CLEAR            = 3'd4,
    INIT_POST_CLEAR       = 3'd5,
    INIT_FINISHED         = 3'd6
  } initiator_state_e;

endpackage

// File: verilog/phase_cdc_pkg.sv
// four-phase crossing types
// handshake states of the source and destination halves of the phase synchronizer

package phase_cdc_pkg;

  // source side of the handshake
  // idle waits for a local phase, then req stays high until ack is seen,
  // then req is low until ack has dropped again
  typedef enum logic [1:0] {
    SRC_IDLE          = 2'd0,
    SRC_WAIT_ACK_HIGH = 2'd1,
    SRC_WAIT_ACK_LOW  = 2'd2
  } cdc_src_state_e;

  // destination side of the handshake
  // idle waits for the synchronized request
  // wait-ack-high offers the phase locally and raises ack once it is taken
  // wait-ack-low holds ack until the request has been withdrawn
  typedef enum logic [1:0] {
    DST_IDLE          = 2'd0,
    DST_WAIT_ACK_HIGH = 2'd1,
    DST_WAIT_ACK_LOW  = 2'd2
  } cdc_dst_state_e;

endpackage

// File: verilog/phase_cdc_src.sv
// phase crossing, source half
// sends one phase word at a time over a four-phase req/ack handshake and only
// reports ready once the far side has taken the word

`timescale 1ns/1ns
`include "clear_sync_config.svh"

module phase_cdc_src
  import clear_seq_pkg::*, phase_cdc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  clear_phase_e phase_i,
  input  logic         valid_i,
  output logic         ready_o,
  output logic         async_req_o,
  output clear_phase_e async_phase_o,
  input  logic         async_ack_i
);

  localparam int unsigned SYNC_STAGES = `CLEAR_SYNC_SYNC_STAGES;
  localparam logic RESET_MSG = `CLEAR_SYNC_CLEAR_ON_RESET;

  cdc_src_state_e           state_q;
  logic                     req_q;
  clear_phase_e             phase_q;
  logic [SYNC_STAGES-1:0]   ack_sync_q;
  logic                     ack_sync;

  // --------------------
  // acknowledge synchronizer
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q[0] <= async_ack_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        ack_sync_q[i] <= ack_sync_q[i-1];
      end
    end
  end

  assign ack_sync = ack_sync_q[SYNC_STAGES-1];

  // --------------------
  // handshake FSM
  // --------------------
  // with the reset message enabled the half leaves reset already requesting
  // isolate, so the far side starts isolating however long this side stays in reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET_MSG ? SRC_WAIT_ACK_HIGH : SRC_IDLE;
      req_q   <= RESET_MSG;
      phase_q <= RESET_MSG ? CLEAR_PHASE_ISOLATE : CLEAR_PHASE_IDLE;
    end else begin
      case (state_q)
        SRC_IDLE: begin
          if (valid_i) begin
            phase_q <= phase_i;
            req_q   <= 1'b1;
            state_q <= SRC_WAIT_ACK_HIGH;
          end
        end
        SRC_WAIT_ACK_HIGH: begin
          if (ack_sync) begin
            req_q   <= 1'b0;
            state_q <= SRC_WAIT_ACK_LOW;
          end
        end
        SRC_WAIT_ACK_LOW: begin
          if (!ack_sync) begin
            state_q <= SRC_IDLE;
          end
        end
        default: state_q <= SRC_IDLE;
      endcase
    end
  end

  // the word counts as delivered only when the whole handshake has closed,
  // so no second phase can overtake the first
  assign ready_o       = (state_q == SRC_WAIT_ACK_LOW) && !ack_sync;
  assign async_req_o   = req_q;
  assign async_phase_o = phase_q;

endmodule

// File: verilog/phase_cdc_dst.sv
// phase crossing, destination half
// synchronizes the request, presents the phase word locally and acknowledges
// only after the local consumer has accepted it

`timescale 1ns/1ns
`include "clear_sync_config.svh"

module phase_cdc_dst
  import clear_seq_pkg::*, phase_cdc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  output clear_phase_e phase_o,
  output logic         valid_o,
  input  logic         ready_i,
  input  logic         async_req_i,
  input  clear_phase_e async_phase_i,
  output logic         async_ack_o
);

  localparam int unsigned SYNC_STAGES = `CLEAR_SYNC_SYNC_STAGES;

  cdc_dst_state_e         state_q;
  logic                   ack_q;
  clear_phase_e           phase_q;
  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_sync;

  // request synchronizer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q[0] <= async_req_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        req_sync_q[i] <= req_sync_q[i-1];
      end
    end
  end

  assign req_sync = req_sync_q[SYNC_STAGES-1];

  // the phase word is only sampled once the request has settled here
  always_ff @(posedge clk_i) begin
    if ((state_q == DST_IDLE) && req_sync) begin
      phase_q <= async_phase_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        DST_IDLE: if (req_sync) state_q <= DST_WAIT_ACK_HIGH;
        // hold off the acknowledge until the consumer takes the phase
        DST_WAIT_ACK_HIGH: begin
          if (ready_i) begin
            ack_q   <= 1'b1;
            state_q <= DST_WAIT_ACK_LOW;
          end
        end
        DST_WAIT_ACK_LOW: begin
          if (!req_sync) begin
            ack_q   <= 1'b0;
            state_q <= DST_IDLE;
          end
        end
        default: state_q <= DST_IDLE;
      endcase
    end
  end

  assign valid_o     = (state_q == DST_WAIT_ACK_HIGH);
  assign phase_o     = phase_q;
  assign async_ack_o = ack_q;

  // the far source may only change its word after seeing our acknowledge drop
  phase_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_sync && $past(req_sync) |-> $stable(async_phase_i));

endmodule

// File: verilog/clear_initiator.sv
// clear sequence initiator
// walks a locally triggered clear through isolate, clear, post-clear and idle,
// handing every phase to the crossing and waiting until the far side has it

`timescale 1ns/1ns
`include "clear_sync_config.svh"

module clear_initiator
  import clear_seq_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         isolate_ack_i,
  input  logic         phase_ready_i,
  output logic         phase_valid_o,
  output clear_phase_e phase_o,
  output logic         isolate_o,
  output logic         clear_o
);

  localparam logic CLEAR_ON_RESET = `CLEAR_SYNC_CLEAR_ON_RESET;

  initiator_state_e state_d, state_q;
  logic             isolate_seen_q;

  // --------------------
  // sequence FSM
  // --------------------
  always_comb begin
    state_d       = state_q;
    phase_valid_o = 1'b0;
    phase_o       = CLEAR_PHASE_IDLE;
    isolate_o     = 1'b1;
    clear_o       = 1'b0;
    case (state_q)
      INIT_IDLE: begin
        isolate_o = 1'b0;
        if (clear_i) state_d = INIT_ISOLATE;
      end
      // the far side and the local isolate acknowledge may answer in either order
      INIT_ISOLATE: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_ISOLATE;
        if (phase_ready_i && isolate_ack_i) state_d = INIT_CLEAR;
        else if (phase_ready_i)             state_d = INIT_WAIT_ISOLATE_ACK;
        else if (isolate_ack_i)             state_d = INIT_WAIT_PHASE_ACK;
      end
      INIT_WAIT_PHASE_ACK: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_ISOLATE;
        if (phase_ready_i) state_d = INIT_CLEAR;
      end
      // the phase is already across, only the local side is still isolating
      INIT_WAIT_ISOLATE_ACK: begin
        phase_o = CLEAR_PHASE_ISOLATE;
        if (isolate_ack_i) state_d = INIT_CLEAR;
      end
      INIT_CLEAR: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_CLEAR;
        clear_o       = 1'b1;
        if (phase_ready_i) state_d = INIT_POST_CLEAR;
      end
      INIT_POST_CLEAR: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_POST_CLEAR;
        if (phase_ready_i) state_d = INIT_FINISHED;
      end
      // isolate stays up until the far side has also returned to idle
      INIT_FINISHED: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_IDLE;
        if (phase_ready_i) state_d = INIT_IDLE;
      end
      default: state_d = INIT_ISOLATE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CLEAR_ON_RESET ? INIT_ISOLATE : INIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // remembers that isolation was acknowledged during the current sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      isolate_seen_q <= 1'b0;
    end else if (state_q == INIT_IDLE) begin
      isolate_seen_q <= 1'b0;
    end else if (isolate_o && isolate_ack_i) begin
      isolate_seen_q <= 1'b1;
    end
  end

  clear_after_isolate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(clear_o) |-> isolate_seen_q);

endmodule

// File: verilog/clear_receiver.sv
// clear sequence receiver
// mirrors the phases sent by the other domain onto the local isolate and clear
// outputs and acknowledges each phase once it is in effect here

`timescale 1ns/1ns

module clear_receiver
  import clear_seq_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         isolate_ack_i,
  input  clear_phase_e phase_i,
  input  logic         phase_valid_i,
  output logic         phase_ready_o,
  output logic         isolate_o,
  output logic         clear_o
);

  clear_phase_e phase_q;
  clear_phase_e active_phase;

  // a pending phase drives the outputs at once so the far side is not kept
  // waiting a cycle, otherwise the last accepted phase holds them
  assign active_phase = phase_valid_i ? phase_i : phase_q;

  always_comb begin
    case (active_phase)
      CLEAR_PHASE_ISOLATE: begin
        isolate_o = 1'b1;
        clear_o   = 1'b0;
      end
      CLEAR_PHASE_CLEAR: begin
        isolate_o = 1'b1;
        clear_o   = 1'b1;
      end
      CLEAR_PHASE_POST_CLEAR: begin
        isolate_o = 1'b1;
        clear_o   = 1'b0;
      end
      default: begin
        isolate_o = 1'b0;
        clear_o   = 1'b0;
      end
    endcase
  end

  // isolate is only taken once the local logic confirms it is isolated,
  // which holds the far side back until then
  assign phase_ready_o = phase_valid_i &&
                         ((phase_i != CLEAR_PHASE_ISOLATE) || isolate_ack_i);

  // current phase of the far sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= CLEAR_PHASE_IDLE;
    end else if (phase_valid_i && phase_ready_o) begin
      phase_q <= phase_i;
    end
  end

endmodule

// File: verilog/clear_sync_half.sv
// one domain of the clear sequencer
// runs the local initiator and the receiver for the far side and merges both
// into the isolate and clear outputs of this domain

`timescale 1ns/1ns

module clear_sync_half
  import clear_seq_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         isolate_ack_i,
  output logic         clear_o,
  output logic         isolate_o,
  output logic         async_req_o,
  output logic         async_ack_o,
  output clear_phase_e async_phase_o,
  input  logic         async_req_i,
  input  logic         async_ack_i,
  input  clear_phase_e async_phase_i
);

  clear_phase_e init_phase, recv_phase;
  logic         init_valid, init_ready;
  logic         recv_valid, recv_ready;
  logic         init_isolate, init_clear;
  logic         recv_isolate, recv_clear;

  // --------------------
  // outgoing sequence
  // --------------------
  clear_initiator initiator_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .isolate_ack_i (isolate_ack_i),
    .phase_ready_i (init_ready),
    .phase_valid_o (init_valid),
    .phase_o       (init_phase),
    .isolate_o     (init_isolate),
    .clear_o       (init_clear)
  );

  phase_cdc_src cdc_src_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .phase_i       (init_phase),
    .valid_i       (init_valid),
    .ready_o       (init_ready),
    .async_req_o   (async_req_o),
    .async_phase_o (async_phase_o),
    .async_ack_i   (async_ack_i)
  );

  // --------------------
  // incoming sequence
  // --------------------
  phase_cdc_dst cdc_dst_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .phase_o       (recv_phase),
    .valid_o       (recv_valid),
    .ready_i       (recv_ready),
    .async_req_i   (async_req_i),
    .async_phase_i (async_phase_i),
    .async_ack_o   (async_ack_o)
  );

  clear_receiver receiver_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .isolate_ack_i (isolate_ack_i),
    .phase_i       (recv_phase),
    .phase_valid_i (recv_valid),
    .phase_ready_o (recv_ready),
    .isolate_o     (recv_isolate),
    .clear_o       (recv_clear)
  );

  // both sequences may run at once, so the outputs follow whichever asks more
  assign clear_o   = init_clear | recv_clear;
  assign isolate_o = init_isolate | recv_isolate;

  // a clear from either source must always sit inside an isolation window
  clear_inside_isolate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_o |-> isolate_o);

endmodule

// File: verilog/clear_sync.sv
// clear sequencer top level
// couples the a and b domain halves so that a clear or reset on either side
// runs the same isolate and clear sequence on both sides in lock-step

`timescale 1ns/1ns

module clear_sync
  import clear_seq_pkg::*;
(
  input  logic a_clk_i,
  input  logic a_rst_ni,
  input  logic a_clear_i,
  input  logic a_isolate_ack_i,
  output logic a_clear_o,
  output logic a_isolate_o,
  input  logic b_clk_i,
  input  logic b_rst_ni,
  input  logic b_clear_i,
  input  logic b_isolate_ack_i,
  output logic b_clear_o,
  output logic b_isolate_o
);

  // channel from a to b, and the acknowledge it gets back
  logic         a2b_req, b2a_ack;
  clear_phase_e a2b_phase;
  // channel from b to a, and the acknowledge it gets back
  logic         b2a_req, a2b_ack;
  clear_phase_e b2a_phase;

  clear_sync_half clear_sync_half_a (
    .clk_i         (a_clk_i),
    .rst_ni        (a_rst_ni),
    .clear_i       (a_clear_i),
    .isolate_ack_i (a_isolate_ack_i),
    .clear_o       (a_clear_o),
    .isolate_o     (a_isolate_o),
    .async_req_o   (a2b_req),
    .async_ack_o   (a2b_ack),
    .async_phase_o (a2b_phase),
    .async_req_i   (b2a_req),
    .async_ack_i   (b2a_ack),
    .async_phase_i (b2a_phase)
  );

  clear_sync_half clear_sync_half_b (
    .clk_i         (b_clk_i),
    .rst_ni        (b_rst_ni),
    .clear_i       (b_clear_i),
    .isolate_ack_i (b_isolate_ack_i),
    .clear_o       (b_clear_o),
    .isolate_o     (b_isolate_o),
    .async_req_o   (b2a_req),
    .async_ack_o   (b2a_ack),
    .async_phase_o (b2a_phase),
    .async_req_i   (a2b_req),
    .async_ack_i   (a2b_ack),
    .async_phase_i (a2b_phase)
  );

endmodule

// File: sim/clear_sync_tb.sv
// clear sequencer testbench
// runs a table of clear and reset triggers on the two domains and checks
// that each side isolates, clears and returns to idle as expected

`timescale 1ns/1ns
`include "clear_sync_config.svh"

module clear_sync_tb;

  localparam int unsigned SYNC_STAGES    = `CLEAR_SYNC_SYNC_STAGES;
  localparam logic        CLEAR_ON_RESET = `CLEAR_SYNC_CLEAR_ON_RESET;
  localparam int unsigned NUM_TESTS      = 6;
  // every entry plus power-up gets twice the sequence bound in slow-clock cycles
  localparam int unsigned TIMEOUT_CYCLES = (NUM_TESTS + 1) * (20 + 16 * SYNC_STAGES) * 2;

  typedef enum logic [2:0] {TRIG_A, TRIG_B, TRIG_BOTH, TRIG_RST_A, TRIG_RST_B} trigger_e;

  logic a_clk_i, a_rst_ni, a_clear_i, a_isolate_ack_i, a_clear_o, a_isolate_o;
  logic b_clk_i, b_rst_ni, b_clear_i, b_isolate_ack_i, b_clear_o, b_isolate_o;

  // stimulus table with one column per array
  string       test_name    [NUM_TESTS];
  trigger_e    test_trigger [NUM_TESTS];
  int unsigned test_ack_a   [NUM_TESTS];
  int unsigned test_ack_b   [NUM_TESTS];
  int unsigned test_clears  [NUM_TESTS];
  logic        test_exact   [NUM_TESTS];

  int unsigned a_ack_delay, b_ack_delay, a_ack_cnt, b_ack_cnt;
  logic        a_iso_sample, b_iso_sample;
  int unsigned a_clear_count, b_clear_count;
  logic        a_clear_prev, b_clear_prev, a_iso_flag, b_iso_flag;
  int unsigned slow_cycles;

  clear_sync clear_sync_inst (
    .a_clk_i, .a_rst_ni, .a_clear_i, .a_isolate_ack_i, .a_clear_o, .a_isolate_o,
    .b_clk_i, .b_rst_ni, .b_clear_i, .b_isolate_ack_i, .b_clear_o, .b_isolate_o
  );

  always #5 a_clk_i = ~a_clk_i;
  always #8 b_clk_i = ~b_clk_i;

  // --------------------
  // isolate acknowledge models
  // --------------------
  // ack rises a set number of own-clock cycles after isolate and drops with it
  always @(posedge a_clk_i) begin
    a_iso_sample = a_isolate_o;
    #2;
    if (!a_iso_sample) begin
      a_isolate_ack_i = 1'b0;
      a_ack_cnt       = 0;
    end else if (a_ack_cnt >= a_ack_delay) begin
      a_isolate_ack_i = 1'b1;
    end else begin
      a_ack_cnt++;
    end
  end

  always @(posedge b_clk_i) begin
    b_iso_sample = b_isolate_o;
    #2;
    if (!b_iso_sample) begin
      b_isolate_ack_i = 1'b0;
      b_ack_cnt       = 0;
    end else if (b_ack_cnt >= b_ack_delay) begin
      b_isolate_ack_i = 1'b1;
    end else begin
      b_ack_cnt++;
    end
  end

  // --------------------
  // output monitors
  // --------------------
  // clear must sit inside isolation and may only rise once isolation is acknowledged
  always @(posedge a_clk_i) begin
    if (a_rst_ni && a_clear_o && !a_isolate_o)
      fail_with("side a drove clear while its isolate output was low");
    if (a_rst_ni && a_clear_o && !a_clear_prev && !a_isolate_ack_i)
      fail_with("side a raised clear before its isolate acknowledge was high");
    if (a_clear_o && !a_clear_prev) a_clear_count++;
    if (a_isolate_o) a_iso_flag = 1'b1;
    a_clear_prev = a_clear_o;
  end

  always @(posedge b_clk_i) begin
    if (b_rst_ni && b_clear_o && !b_isolate_o)
      fail_with("side b drove clear while its isolate output was low");
    if (b_rst_ni && b_clear_o && !b_clear_prev && !b_isolate_ack_i)
      fail_with("side b raised clear before its isolate acknowledge was high");
    if (b_clear_o && !b_clear_prev) b_clear_count++;
    if (b_isolate_o) b_iso_flag = 1'b1;
    b_clear_prev = b_clear_o;
  end

  // whole-run watchdog counted in the slower clock
  always @(posedge b_clk_i) begin
    slow_cycles++;
    if (slow_cycles > TIMEOUT_CYCLES)
      fail_with("timeout, a clear sequence did not return to idle in time");
  end

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s expected %0b actual %0b", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp,
                             input int unsigned act);
    if (act != exp) begin
      $display("Mismatch %s expected %0d actual %0d", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic add_entry(input int idx, input string name, input trigger_e trig,
                           input int unsigned ack_a, input int unsigned ack_b,
                           input int unsigned clears, input logic exact);
    test_name[idx]    = name;
    test_trigger[idx] = trig;
    test_ack_a[idx]   = ack_a;
    test_ack_b[idx]   = ack_b;
    test_clears[idx]  = clears;
    test_exact[idx]   = exact;
  endtask

  // two concurrent sequences may or may not merge their clear windows,
  // so the both-sides entry only asks for a minimum
  task automatic load_table();
    add_entry(0, "clear_a_short", TRIG_A,     1,  1,  1, 1'b1);
    add_entry(1, "clear_b_long",  TRIG_B,     12, 10, 1, 1'b1);
    add_entry(2, "clear_a_slowa", TRIG_A,     12, 0,  1, 1'b1);
    add_entry(3, "clear_both",    TRIG_BOTH,  3,  5,  1, 1'b0);
    add_entry(4, "reset_a",       TRIG_RST_A, 2,  6,  1, 1'b1);
    add_entry(5, "reset_b",       TRIG_RST_B, 4,  2,  1, 1'b1);
  endtask

  // a one-cycle clear pulse must raise the local isolate on the next cycle
  task automatic pulse_clear_a(input string name);
    @(posedge a_clk_i);
    #2 a_clear_i = 1'b1;
    @(posedge a_clk_i);
    #2 a_clear_i = 1'b0;
    check_bit({name, " a isolate after clear"}, 1'b1, a_isolate_o);
  endtask

  task automatic pulse_clear_b(input string name);
    @(posedge b_clk_i);
    #2 b_clear_i = 1'b1;
    @(posedge b_clk_i);
    #2 b_clear_i = 1'b0;
    check_bit({name, " b isolate after clear"}, 1'b1, b_isolate_o);
  endtask

  task automatic pulse_reset_a(input string name);
    @(posedge a_clk_i);
    #2 a_rst_ni = 1'b0;
    repeat (3) @(posedge a_clk_i);
    check_bit({name, " a isolate in reset"}, CLEAR_ON_RESET, a_isolate_o);
    #2 a_rst_ni = 1'b1;
  endtask

  task automatic pulse_reset_b(input string name);
    @(posedge b_clk_i);
    #2 b_rst_ni = 1'b0;
    repeat (3) @(posedge b_clk_i);
    check_bit({name, " b isolate in reset"}, CLEAR_ON_RESET, b_isolate_o);
    #2 b_rst_ni = 1'b1;
  endtask

  // the initiating side drops isolate last, so both low means the run is over
  task automatic wait_sequence_done();
    while (a_isolate_o || b_isolate_o) @(posedge b_clk_i);
    repeat (4) @(posedge b_clk_i);
  endtask

  task automatic check_outcome(input string name, input int unsigned clears,
                               input logic exact);
    if (exact) begin
      check_count({name, " a clear pulses"}, clears, a_clear_count);
      check_count({name, " b clear pulses"}, clears, b_clear_count);
    end else begin
      check_bit({name, " a enough clears"}, 1'b1, a_clear_count >= clears);
      check_bit({name, " b enough clears"}, 1'b1, b_clear_count >= clears);
    end
    check_bit({name, " a isolate seen"}, clears != 0, a_iso_flag);
    check_bit({name, " b isolate seen"}, clears != 0, b_iso_flag);
    check_bit({name, " a isolate idle"}, 1'b0, a_isolate_o);
    check_bit({name, " b isolate idle"}, 1'b0, b_isolate_o);
    check_bit({name, " a clear idle"}, 1'b0, a_clear_o);
    check_bit({name, " b clear idle"}, 1'b0, b_clear_o);
  endtask

  task automatic run_test(input int idx);
    string       name;
    int unsigned clears;
    name   = test_name[idx];
    clears = test_clears[idx];
    // without clear-on-reset a reset pulse must leave both sides idle
    if (!CLEAR_ON_RESET &&
        (test_trigger[idx] == TRIG_RST_A || test_trigger[idx] == TRIG_RST_B)) begin
      clears = 0;
    end
    a_ack_delay   = test_ack_a[idx] + ($urandom % 8);
    b_ack_delay   = test_ack_b[idx] + ($urandom % 8);
    a_clear_count = 0;
    b_clear_count = 0;
    a_iso_flag    = 1'b0;
    b_iso_flag    = 1'b0;
    case (test_trigger[idx])
      TRIG_A:     pulse_clear_a(name);
      TRIG_B:     pulse_clear_b(name);
      TRIG_BOTH: begin
        fork
          pulse_clear_a(name);
          pulse_clear_b(name);
        join
      end
      TRIG_RST_A: pulse_reset_a(name);
      default:    pulse_reset_b(name);
    endcase
    wait_sequence_done();
    check_outcome(name, clears, test_exact[idx]);
  endtask

  initial begin
    a_clk_i         = 1'b0;
    b_clk_i         = 1'b0;
    a_rst_ni        = 1'b0;
    b_rst_ni        = 1'b0;
    a_clear_i       = 1'b0;
    b_clear_i       = 1'b0;
    a_isolate_ack_i = 1'b0;
    b_isolate_ack_i = 1'b0;
    a_ack_cnt       = 0;
    b_ack_cnt       = 0;
    a_clear_count   = 0;
    b_clear_count   = 0;
    a_clear_prev    = 1'b0;
    b_clear_prev    = 1'b0;
    a_iso_flag      = 1'b0;
    b_iso_flag      = 1'b0;
    slow_cycles     = 0;
    void'($urandom(89));
    load_table();
    a_ack_delay = 2 + ($urandom % 8);
    b_ack_delay = 3 + ($urandom % 8);

    // power-up reset of both sides starts one sequence from each side
    repeat (16) @(posedge a_clk_i);
    check_bit("powerup a isolate in reset", CLEAR_ON_RESET, a_isolate_o);
    check_bit("powerup b isolate in reset", CLEAR_ON_RESET, b_isolate_o);
    check_bit("powerup a clear in reset", 1'b0, a_clear_o);
    check_bit("powerup b clear in reset", 1'b0, b_clear_o);
    #2;
    a_rst_ni = 1'b1;
    b_rst_ni = 1'b1;
    wait_sequence_done();
    check_outcome("powerup", CLEAR_ON_RESET ? 1 : 0, !CLEAR_ON_RESET);

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end

    $display("Test OK");
    $finish;
  end

endmodule

// File: clear_sync.f
+incdir+verilog
verilog/clear_seq_pkg.sv
verilog/phase_cdc_pkg.sv
verilog/phase_cdc_src.sv
verilog/phase_cdc_dst.sv
verilog/clear_initiator.sv
verilog/clear_receiver.sv
verilog/clear_sync_half.sv
verilog/clear_sync.sv
sim/clear_sync_tb.sv

// File: Bender.yml
package:
  name: clear_sync

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/clear_seq_pkg.sv
      - verilog/phase_cdc_pkg.sv
      - verilog/phase_cdc_src.sv
      - verilog/phase_cdc_dst.sv
      - verilog/clear_initiator.sv
      - verilog/clear_receiver.sv
      - verilog/clear_sync_half.sv
      - verilog/clear_sync.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/clear_sync_tb.sv
